//--- armCtrlPkg.sv
package armCtrlPkg;

	typedef logic [9:0] stateT; // Microstate, same as microstore address

	// Field layout of the 32-bit instruction word, MSB first
	typedef struct packed {
		logic [3:0]  cond;      // Bits 31:28
		logic [2:0]  cls;       // Bits 27:25
		logic        preIdx;    // P, opcode[3] in data processing
		logic        up;        // U, opcode[2]
		logic        byteOp;    // B, opcode[1]
		logic        writeBack; // W, opcode[0]
		logic        load;      // L, or S in data processing
		logic [11:0] restHi;    // Bits 19:8
		logic        bit7;
		logic        bit6;
		logic        bit5;
		logic        bit4;
		logic [3:0]  restLo;    // Bits 3:0
	} instrWordT;

	typedef enum logic [2:0] {
		clsDpReg,
		clsDpImm,   // Immediate and shifted register share this path
		clsLdStImm,
		clsLdStReg,
		clsBranch,
		clsUnknown
	} instrClassE;

	typedef enum logic [3:0] {
		opAnd = 4'b0000,
		opEor = 4'b0001,
		opSub = 4'b0010,
		opRsb = 4'b0011,
		opAdd = 4'b0100,
		opAdc = 4'b0101,
		opSbc = 4'b0110,
		opRsc = 4'b0111,
		opTst = 4'b1000,
		opTeq = 4'b1001,
		opCmp = 4'b1010,
		opCmn = 4'b1011,
		opOrr = 4'b1100,
		opMov = 4'b1101,
		opBic = 4'b1110,
		opMvn = 4'b1111
	} dpOpcodeE;

	typedef struct packed {
		logic load;
		logic preIndex;  // P and W both set
		logic postIndex; // P clear
		logic byteSize;
		logic subtract;  // U clear
	} memModeT;

	typedef struct packed {
		instrClassE cls;
		logic       testOp;
		logic       setFlags;
		logic       link;
		memModeT    memMode;
	} decodedInstrT;

	// Class codes in bits 27:25
	localparam logic [2:0] CLASS_DP       = 3'b000;
	localparam logic [2:0] CLASS_DP_IMM   = 3'b001;
	localparam logic [2:0] CLASS_LDST_IMM = 3'b010;
	localparam logic [2:0] CLASS_LDST_REG = 3'b011;
	localparam logic [2:0] CLASS_BRANCH   = 3'b101;

	localparam stateT STATE_FETCH0     = 10'd0;
	localparam stateT STATE_FETCH1     = 10'd1;
	localparam stateT STATE_FETCH2     = 10'd2;
	localparam stateT STATE_FETCH_WAIT = 10'd3;
	localparam stateT STATE_DECODE     = 10'd4;

	localparam stateT STATE_DP_REG     = 10'd5;
	localparam stateT STATE_DP_IMM     = 10'd6;
	localparam stateT STATE_DP_REG_S   = 10'd7;
	localparam stateT STATE_DP_IMM_S   = 10'd8;
	localparam stateT STATE_DP_REG_TST = 10'd9;
	localparam stateT STATE_DP_IMM_TST = 10'd10;

	localparam stateT LDR_IMM_BASE = 10'd11;
	localparam stateT LDR_REG_BASE = 10'd15;
	localparam stateT STR_IMM_BASE = 10'd59;
	localparam stateT STR_REG_BASE = 10'd63;

	localparam stateT OFS_PRE  = 10'd8;
	localparam stateT OFS_POST = 10'd16;
	localparam stateT OFS_BYTE = 10'd24;
	localparam stateT OFS_SUB  = 10'd96;

	localparam stateT LD_ADD_LO = 10'd11;
	localparam stateT LD_ADD_HI = 10'd58;
	localparam stateT ST_ADD_LO = 10'd59;
	localparam stateT ST_ADD_HI = 10'd106;
	localparam stateT LD_SUB_LO = 10'd107;
	localparam stateT LD_SUB_HI = 10'd154;
	localparam stateT ST_SUB_LO = 10'd155;
	localparam stateT ST_SUB_HI = 10'd202;

	localparam stateT STATE_B  = 10'd459;
	localparam stateT STATE_BL = 10'd460;

	function automatic logic stateInRange(input stateT s, input stateT lo, input stateT hi);
		return (s >= lo) && (s <= hi);
	endfunction

endpackage

//--- armCtrlTop.sv
`timescale 1ns/10ps

module armCtrlTop (
	input  logic                  clk,
	input  logic                  rstN,
	input  armCtrlPkg::instrWordT ir,    // Held stable by the datapath
	input  logic                  cond,  // Condition check result
	input  logic                  moc,   // Memory operation complete
	output armCtrlPkg::stateT     state
);
	import armCtrlPkg::*;

	decodedInstrT decoded;
	stateT        entryState;

	instrClassifier u_classifier (
		.ir      (ir),
		.decoded (decoded)
	);

	// Combinational, valid whenever the sequencer sits in decode
	entryStateMapper u_mapper (
		.cond       (cond),
		.decoded    (decoded),
		.entryState (entryState)
	);

	microSequencer u_sequencer (
		.clk        (clk),
		.rstN       (rstN),
		.moc        (moc),
		.entryState (entryState),
		.state      (state)
	);

endmodule

//--- build.f
+incdir+.
armCtrlPkg.sv
instrClassifier.sv
entryStateMapper.sv
microSequencer.sv
armCtrlTop.sv
tbArmCtrl.sv

//--- entryStateMapper.sv
`timescale 1ns/10ps

module entryStateMapper (
	input  logic                     cond,
	input  armCtrlPkg::decodedInstrT decoded,
	output armCtrlPkg::stateT        entryState
);
	import armCtrlPkg::*;

	logic isLdSt;
	logic inLoadRange;
	logic inStoreRange;

	// Test ops win over the S bit, as in the microstore layout
	function automatic stateT dpEntry(
		input logic  testOp,
		input logic  setFlags,
		input stateT tstState,
		input stateT flagState,
		input stateT plainState
	);
		if (testOp) begin
			return tstState;
		end
		if (setFlags) begin
			return flagState;
		end
		return plainState;
	endfunction

	// Each addressing variant sits at a fixed distance from its base
	function automatic stateT ldStEntry(input memModeT mode, input stateT base);
		return base
			+ (mode.preIndex  ? OFS_PRE  : '0)
			+ (mode.postIndex ? OFS_POST : '0)
			+ (mode.byteSize  ? OFS_BYTE : '0)
			+ (mode.subtract  ? OFS_SUB  : '0);
	endfunction

	assign isLdSt = (decoded.cls == clsLdStImm) || (decoded.cls == clsLdStReg);

	always_comb begin
		entryState = STATE_FETCH1; // Failed condition goes back to fetch
		if (cond) begin
			case (decoded.cls)
				clsDpReg: entryState = dpEntry(decoded.testOp, decoded.setFlags,
					STATE_DP_REG_TST, STATE_DP_REG_S, STATE_DP_REG);
				clsDpImm: entryState = dpEntry(decoded.testOp, decoded.setFlags,
					STATE_DP_IMM_TST, STATE_DP_IMM_S, STATE_DP_IMM);
				clsLdStImm: entryState = ldStEntry(decoded.memMode,
					decoded.memMode.load ? LDR_IMM_BASE : STR_IMM_BASE);
				clsLdStReg: entryState = ldStEntry(decoded.memMode,
					decoded.memMode.load ? LDR_REG_BASE : STR_REG_BASE);
				clsBranch: entryState = decoded.link ? STATE_BL : STATE_B;
				default: entryState = STATE_FETCH1; // Unknown instruction
			endcase
		end

		inLoadRange = stateInRange(entryState, LD_ADD_LO, LD_ADD_HI)
			|| stateInRange(entryState, LD_SUB_LO, LD_SUB_HI);
		inStoreRange = stateInRange(entryState, ST_ADD_LO, ST_ADD_HI)
			|| stateInRange(entryState, ST_SUB_LO, ST_SUB_HI);

		// The sequencer's step rules rely on entries landing at offset 3 of a group
		if (cond && isLdSt) begin
			assert ((entryState[1:0] == 2'b11)
				&& (decoded.memMode.load ? inLoadRange : inStoreRange))
			else $error("Load/store entry %0d outside its range", entryState);
		end
	end

endmodule

//--- instrClassifier.sv
`timescale 1ns/10ps

module instrClassifier (
	input  armCtrlPkg::instrWordT    ir,
	output armCtrlPkg::decodedInstrT decoded
);
	import armCtrlPkg::*;

	dpOpcodeE opcode;
	memModeT  ldStMode;
	logic     isTestOp;
	logic     isDpReg;
	logic     isDpImm;
	logic     isShiftReg;
	logic     isShiftImm;
	logic     isLdStImm;
	logic     isLdStReg;
	logic     isBranch;

	assign opcode   = dpOpcodeE'({ir.preIdx, ir.up, ir.byteOp, ir.writeBack});
	assign isTestOp = (opcode == opTst) || (opcode == opTeq);

	// Raw class matches, priority is applied below
	assign isDpReg    = (ir.cls == CLASS_DP) && !ir.bit6 && !ir.bit5 && !ir.bit4;
	assign isDpImm    = (ir.cls == CLASS_DP_IMM);
	assign isShiftReg = (ir.cls == CLASS_DP) && !ir.bit7 && ir.bit4;
	assign isShiftImm = (ir.cls == CLASS_DP) && !ir.bit4;
	assign isLdStImm  = (ir.cls == CLASS_LDST_IMM);
	assign isLdStReg  = (ir.cls == CLASS_LDST_REG) && !ir.bit4; // Bit 4 set is media space
	assign isBranch   = (ir.cls == CLASS_BRANCH);

	// Addressing mode 2 flags
	assign ldStMode.load      = ir.load;
	assign ldStMode.preIndex  = ir.preIdx && ir.writeBack;
	assign ldStMode.postIndex = !ir.preIdx;
	assign ldStMode.byteSize  = ir.byteOp;
	assign ldStMode.subtract  = !ir.up;

	always_comb begin
		decoded.cls      = clsUnknown; // Mode 3, mode 4 and undefined end here
		decoded.testOp   = 1'b0;
		decoded.setFlags = 1'b0;
		decoded.link     = 1'b0;
		decoded.memMode  = '0;
		if (isDpReg) begin
			decoded.cls      = clsDpReg;
			decoded.testOp   = isTestOp;
			decoded.setFlags = ir.load;
		end else if (isDpImm || isShiftReg || isShiftImm) begin
			// Shifted register operands run the immediate routine
			decoded.cls      = clsDpImm;
			decoded.testOp   = isTestOp;
			decoded.setFlags = ir.load;
		end else if (isLdStImm) begin
			decoded.cls     = clsLdStImm;
			decoded.memMode = ldStMode;
		end else if (isLdStReg) begin
			decoded.cls     = clsLdStReg;
			decoded.memMode = ldStMode;
		end else if (isBranch) begin
			decoded.cls  = clsBranch;
			decoded.link = ir.preIdx; // L bit of B/BL sits at bit 24
		end
	end

endmodule

//--- microSequencer.sv
`timescale 1ns/10ps

module microSequencer (
	input  logic              clk,
	input  logic              rstN,
	input  logic              moc,
	input  armCtrlPkg::stateT entryState,
	output armCtrlPkg::stateT state
);
	import armCtrlPkg::*;

	typedef enum logic [1:0] {
		kindFetch,
		kindLoad,
		kindStore,
		kindOther
	} stateKindE;

	stateKindE  kind;
	stateT      nextState;
	stateT      stepState;
	logic [1:0] groupOfs;
	logic       waitState;

	assign groupOfs  = state[1:0]; // Position inside a four-state group
	assign stepState = state + 10'd1;

	always_comb begin
		if (state <= STATE_DECODE) begin
			kind = kindFetch;
		end else if (stateInRange(state, LD_ADD_LO, LD_ADD_HI)
			|| stateInRange(state, LD_SUB_LO, LD_SUB_HI)) begin
			kind = kindLoad;
		end else if (stateInRange(state, ST_ADD_LO, ST_ADD_HI)
			|| stateInRange(state, ST_SUB_LO, ST_SUB_HI)) begin
			kind = kindStore;
		end else begin
			kind = kindOther; // Data processing and branch bodies
		end
	end

	always_comb begin
		nextState = STATE_FETCH1;
		case (kind)
			kindFetch: begin
				case (state)
					STATE_FETCH0:     nextState = STATE_FETCH1;
					STATE_FETCH1:     nextState = STATE_FETCH2;
					STATE_FETCH2:     nextState = STATE_FETCH_WAIT;
					STATE_FETCH_WAIT: nextState = moc ? STATE_DECODE : state;
					STATE_DECODE:     nextState = entryState;
					default:          nextState = STATE_FETCH1;
				endcase
			end
			kindLoad: begin
				case (groupOfs)
					2'd1:    nextState = moc ? stepState : state; // Memory read
					2'd2:    nextState = STATE_FETCH1;
					default: nextState = stepState;
				endcase
			end
			kindStore: begin
				if (groupOfs == 2'd2) begin
					nextState = moc ? STATE_FETCH1 : state; // Memory write
				end else begin
					nextState = stepState;
				end
			end
			default: nextState = STATE_FETCH1;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= STATE_FETCH0;
		end else begin
			state <= nextState;
		end
	end

	// Wait states by position, independent of the next-state case above
	assign waitState = (state == STATE_FETCH_WAIT)
		|| ((kind == kindLoad) && (groupOfs == 2'd1))
		|| ((kind == kindStore) && (groupOfs == 2'd2));

	decodeTakesEntry: assert property (@(posedge clk) disable iff (!rstN)
		(state == STATE_DECODE) |=> (state == $past(entryState)))
	else $error("Decode did not load entry state");

	waitHoldsWithoutMoc: assert property (@(posedge clk) disable iff (!rstN)
		(waitState && !moc) |=> $stable(state))
	else $error("Wait state %0d left without moc", $past(state));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tbArmCtrl -o simArmCtrl

# The simulation exits non-zero on failure, the message search decides the result
output=$(./obj_dir/simArmCtrl 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "test passed"; then
	exit 0
fi
exit 1

//--- tbArmCtrlRef.svh
// Entry state of the micro-routine, decoded straight from the instruction bits
function automatic stateT refEntryState(input logic [31:0] w, input logic condOk);
	logic [2:0] c;
	logic       isTest;
	logic       dpReg;
	logic       dpOther;
	logic       ldSt;
	stateT      e;
	c       = w[27:25];
	isTest  = (w[24:21] == 4'b1000) || (w[24:21] == 4'b1001); // TST, TEQ
	dpReg   = (c == CLASS_DP) && (w[6:4] == 3'b000);
	dpOther = (c == CLASS_DP_IMM) || ((c == CLASS_DP) && (!w[4] || !w[7]));
	ldSt    = (c == CLASS_LDST_IMM) || ((c == CLASS_LDST_REG) && !w[4]);
	if (!condOk) begin
		return STATE_FETCH1;
	end
	if (dpReg) begin
		return isTest ? STATE_DP_REG_TST : (w[20] ? STATE_DP_REG_S : STATE_DP_REG);
	end
	if (dpOther) begin
		return isTest ? STATE_DP_IMM_TST : (w[20] ? STATE_DP_IMM_S : STATE_DP_IMM);
	end
	if (ldSt) begin
		if (w[20]) begin
			e = c[0] ? LDR_REG_BASE : LDR_IMM_BASE;
		end else begin
			e = c[0] ? STR_REG_BASE : STR_IMM_BASE;
		end
		if (w[24] && w[21]) begin
			e = e + OFS_PRE; // Pre-indexed with write-back
		end
		if (!w[24]) begin
			e = e + OFS_POST;
		end
		if (w[22]) begin
			e = e + OFS_BYTE;
		end
		if (!w[23]) begin
			e = e + OFS_SUB;
		end
		return e;
	end
	if (c == CLASS_BRANCH) begin
		return w[24] ? STATE_BL : STATE_B;
	end
	return STATE_FETCH1; // Dropped classes and undefined words
endfunction

// Expected state after the next rising edge
function automatic stateT refNextState(
	input stateT       cur,
	input logic [31:0] w,
	input logic        condOk,
	input logic        mocIn
);
	logic  isLoad;
	logic  isStore;
	stateT ofs;
	isLoad  = ((cur >= LD_ADD_LO) && (cur <= LD_ADD_HI))
		|| ((cur >= LD_SUB_LO) && (cur <= LD_SUB_HI));
	isStore = ((cur >= ST_ADD_LO) && (cur <= ST_ADD_HI))
		|| ((cur >= ST_SUB_LO) && (cur <= ST_SUB_HI));
	ofs     = cur % 10'd4;
	case (cur)
		STATE_FETCH0:     return STATE_FETCH1;
		STATE_FETCH1:     return STATE_FETCH2;
		STATE_FETCH2:     return STATE_FETCH_WAIT;
		STATE_FETCH_WAIT: return mocIn ? STATE_DECODE : cur;
		STATE_DECODE:     return refEntryState(w, condOk);
		default:          ;
	endcase
	if (isLoad) begin
		if (ofs == 10'd2) begin
			return STATE_FETCH1;
		end
		if ((ofs == 10'd1) && !mocIn) begin
			return cur; // Waiting on the read
		end
		return cur + 10'd1;
	end
	if (isStore) begin
		if (ofs == 10'd2) begin
			return mocIn ? STATE_FETCH1 : cur;
		end
		return cur + 10'd1;
	end
	return STATE_FETCH1;
endfunction

task automatic checkState(input string name, input stateT actual, input stateT expectedVal);
	if (actual !== expectedVal) begin
		failRun($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual,
			expectedVal));
	end
endtask

//--- tbArmCtrl.sv
`timescale 1ns/10ps

module tbArmCtrl;
	import armCtrlPkg::*;

	logic        clk;
	logic        rstN;
	instrWordT   ir;
	logic        cond;
	logic        moc;
	stateT       state;
	stateT       expected;
	logic        expectValid;
	logic [32:0] directed[$]; // {cond, instruction word}

	armCtrlTop u_dut (
		.clk   (clk),
		.rstN  (rstN),
		.ir    (ir),
		.cond  (cond),
		.moc   (moc),
		.state (state)
	);

	always #5 clk = ~clk;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	`include "tbArmCtrlRef.svh"

	function automatic logic [31:0] buildDpWord(input int form, input logic [3:0] op,
		input logic s);
		logic [31:0] w;
		w        = $urandom;
		w[24:21] = op;
		w[20]    = s;
		case (form)
			0: begin
				w[27:25] = CLASS_DP;
				w[6:4]   = 3'b000; // Plain register operand
			end
			1: w[27:25] = CLASS_DP_IMM;
			2: begin
				w[27:25] = CLASS_DP;
				w[7]     = 1'b0;
				w[4]     = 1'b1; // Shift by register
			end
			default: begin
				w[27:25] = CLASS_DP;
				w[6:5]   = 2'b01;
				w[4]     = 1'b0; // Shift by immediate
			end
		endcase
		return w;
	endfunction

	function automatic logic [31:0] buildLdStWord(input logic imm, input logic load,
		input logic p, input logic u, input logic b, input logic wb);
		logic [31:0] w;
		w        = $urandom;
		w[27:25] = imm ? CLASS_LDST_IMM : CLASS_LDST_REG;
		w[24]    = p;
		w[23]    = u;
		w[22]    = b;
		w[21]    = wb;
		w[20]    = load;
		if (!imm) begin
			w[4] = 1'b0; // Keep out of media space
		end
		return w;
	endfunction

	function automatic logic [31:0] buildBranchWord(input logic link);
		logic [31:0] w;
		w        = $urandom;
		w[27:25] = CLASS_BRANCH;
		w[24]    = link;
		return w;
	endfunction

	// Weighted mix of kept classes, dropped classes and raw words
	function automatic logic [31:0] drawInstruction();
		logic [31:0] rnd;
		logic [31:0] w;
		int          sel;
		rnd = $urandom;
		sel = int'($urandom_range(0, 9));
		w   = $urandom;
		if (sel <= 2) begin
			w = buildDpWord(int'(rnd[1:0]), rnd[5:2], rnd[6]);
		end else if (sel <= 5) begin
			w = buildLdStWord(rnd[0], rnd[1], rnd[2], rnd[3], rnd[4], rnd[5]);
		end else if (sel == 6) begin
			w = buildBranchWord(rnd[0]);
		end else if (sel == 7) begin
			w[27:25] = 3'b000; // Extra load/store
			w[7]     = 1'b1;
			w[4]     = 1'b1;
		end else if (sel == 8) begin
			w[27:25] = 3'b100; // Block transfer
		end
		return w;
	endfunction

	task automatic buildDirectedList();
		logic [3:0] op;
		directed.push_back({1'b0, buildDpWord(0, 4'b0100, 1'b0)}); // Failed condition
		for (int form = 0; form < 4; form++) begin
			for (int k = 0; k < 3; k++) begin
				op = (k == 0) ? 4'b0100 : {3'b100, k[0]};
				for (int s = 0; s < 2; s++) begin
					directed.push_back({1'b1, buildDpWord(form, op, s[0])});
				end
			end
		end
		for (int c = 0; c < 64; c++) begin
			directed.push_back({1'b1, buildLdStWord(c[0], c[1], c[2], c[3], c[4], c[5])});
		end
		directed.push_back({1'b1, buildBranchWord(1'b0)});
		directed.push_back({1'b1, buildBranchWord(1'b1)});
		directed.push_back({1'b1, 32'he1d000b4}); // LDRH, extra load/store
		directed.push_back({1'b1, 32'he8bd4010}); // LDM
		directed.push_back({1'b1, 32'he6000010}); // Media space
		directed.push_back({1'b1, 32'hee010f10}); // Coprocessor
	endtask

	task automatic driveInputs();
		logic [31:0] rnd;
		logic [32:0] entry;
		rnd = $urandom;
		moc = rnd[0];
		if (state == STATE_DECODE) begin
			if (directed.size() > 0) begin
				entry = directed.pop_front();
			end else begin
				entry = {(rnd[3:2] != 2'b00), drawInstruction()};
			end
			cond = entry[32];
			ir   = entry[31:0];
		end
	endtask

	task automatic waitForState(input stateT target, input int maxCycles);
		int n;
		n = 0;
		while (state !== target) begin
			if (n == maxCycles) begin
				failRun($sformatf("Timed out waiting for state %0d", target));
			end
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	task automatic resetInRoutine();
		int n;
		n = 0;
		while (!((state >= LD_ADD_LO) && (state <= ST_SUB_HI))) begin
			if (n == 600) begin
				failRun("Timed out waiting for a load or store routine");
			end
			@(posedge clk);
			#1;
			driveInputs();
			n++;
		end
		rstN = 1'b0;
		#1;
		checkState("state", state, STATE_FETCH0); // Cleared without a clock edge
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		waitForState(STATE_FETCH_WAIT, 10);
	endtask

	// Inputs settle 1 ns after the rising edge, so sample on the falling edge
	always @(negedge clk) begin
		if (!rstN) begin
			checkState("state", state, STATE_FETCH0);
			expectValid = 1'b0;
		end else begin
			if (expectValid) begin
				checkState("state", state, expected);
			end
			expected    = refNextState(state, ir, cond, moc);
			expectValid = 1'b1;
		end
	end

	initial begin
		int cycle;
		clk         = 1'b0;
		rstN        = 1'b0;
		ir          = '0;
		cond        = 1'b0;
		moc         = 1'b0;
		expectValid = 1'b0;
		void'($urandom(80565));
		buildDirectedList();
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
		waitForState(STATE_FETCH_WAIT, 10);
		repeat (3) begin
			@(posedge clk); // moc still low
			#1;
		end
		checkState("state", state, STATE_FETCH_WAIT);
		for (cycle = 0; cycle < 3000; cycle++) begin
			@(posedge clk);
			#1;
			driveInputs();
			if (cycle == 2000) begin
				resetInRoutine();
			end
		end
		if (directed.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			failRun("Not all directed instructions reached decode");
		end
	end

endmodule
